// ==== source/lc3b_pkg.sv ====
package lc3b_pkg;

	typedef logic [15:0] lc3b_word;
	typedef logic [2:0] lc3b_reg;
	typedef logic [2:0] lc3b_nzp;
	typedef logic [3:0] lc3b_imm4;

	// LC-3b opcode field values
	typedef enum logic [3:0] {
		op_br   = 4'b0000,
		op_add  = 4'b0001,
		op_ldb  = 4'b0010,
		op_stb  = 4'b0011,
		op_jsr  = 4'b0100,
		op_and  = 4'b0101,
		op_ldr  = 4'b0110,
		op_str  = 4'b0111,
		op_rti  = 4'b1000,
		op_not  = 4'b1001,
		op_ldi  = 4'b1010,
		op_sti  = 4'b1011,
		op_jmp  = 4'b1100,
		op_shf  = 4'b1101,
		op_lea  = 4'b1110,
		op_trap = 4'b1111
	} lc3b_opcode;

	typedef enum logic [2:0] {
		alu_add,
		alu_and,
		alu_not,
		alu_sll,
		alu_srl,
		alu_sra
	} lc3b_aluop;

	localparam int num_regs = 8;

	// zero flag set after reset
	localparam lc3b_nzp cc_reset = 3'b010;

endpackage : lc3b_pkg

// ==== source/lc3b_result_if.sv ====
`timescale 1ns/100ps

interface lc3b_result_if;
	import lc3b_pkg::*;

	logic valid;
	logic write_en;
	lc3b_reg dest;
	lc3b_word data;

	modport source (
		output valid,
		output write_en,
		output dest,
		output data
	);

	modport sink (
		input valid,
		input write_en,
		input dest,
		input data
	);

endinterface : lc3b_result_if

// ==== source/lc3b_regfile.sv ====
`timescale 1ns/100ps

module lc3b_regfile
(
	input logic clk,
	input logic rst,
	input lc3b_pkg::lc3b_reg src_a,
	input lc3b_pkg::lc3b_reg src_b,
	output lc3b_pkg::lc3b_word reg_a,
	output lc3b_pkg::lc3b_word reg_b,
	lc3b_result_if.sink wr
);
	import lc3b_pkg::*;

	lc3b_word regs [num_regs];
	logic wr_active;

	assign wr_active = wr.valid && wr.write_en;

	always_ff @(posedge clk) begin
		if (rst) begin
			for (int i = 0; i < num_regs; i++) begin
				regs[i] <= '0;
			end
		end else if (wr_active) begin
			regs[wr.dest] <= wr.data;
		end
	end

	// write-through so the instruction three behind sees this write
	always_comb begin
		reg_a = regs[src_a];
		reg_b = regs[src_b];
		if (wr_active && wr.dest == src_a) begin
			reg_a = wr.data;
		end
		if (wr_active && wr.dest == src_b) begin
			reg_b = wr.data;
		end
	end

endmodule : lc3b_regfile

// ==== source/lc3b_decode.sv ====
`timescale 1ns/100ps

module lc3b_decode
(
	input logic clk,
	input logic rst,
	input logic instr_valid,
	input lc3b_pkg::lc3b_word instr,

	output lc3b_pkg::lc3b_reg src_a,
	output lc3b_pkg::lc3b_reg src_b,
	input lc3b_pkg::lc3b_word reg_a,
	input lc3b_pkg::lc3b_word reg_b,

	output logic id_ex_valid,
	output logic id_ex_write,
	output lc3b_pkg::lc3b_aluop id_ex_aluop,
	output lc3b_pkg::lc3b_reg id_ex_dest,
	output lc3b_pkg::lc3b_reg id_ex_sr1,
	output lc3b_pkg::lc3b_reg id_ex_sr2,
	output lc3b_pkg::lc3b_word id_ex_a,
	output lc3b_pkg::lc3b_word id_ex_b,
	output logic id_ex_imm_sel,
	output lc3b_pkg::lc3b_word id_ex_imm
);
	import lc3b_pkg::*;

	logic if_id_valid;
	lc3b_word if_id_instr;

	lc3b_opcode opcode;
	lc3b_reg dest;
	lc3b_word imm5_ext;
	lc3b_imm4 shamt;
	logic dec_write;
	lc3b_aluop dec_aluop;
	logic dec_imm_sel;
	lc3b_word dec_imm;

	// IF/ID
	always_ff @(posedge clk) begin
		if (rst) begin
			if_id_valid <= 1'b0;
		end else begin
			if_id_valid <= instr_valid;
		end
		if_id_instr <= instr;
	end

	assign opcode = lc3b_opcode'(if_id_instr[15:12]);
	assign dest = if_id_instr[11:9];
	assign src_a = if_id_instr[8:6];
	assign src_b = if_id_instr[2:0];
	assign imm5_ext = {{11{if_id_instr[4]}}, if_id_instr[4:0]};
	assign shamt = if_id_instr[3:0];

	always_comb begin
		dec_write = 1'b0;
		dec_aluop = alu_add;
		dec_imm_sel = 1'b0;
		dec_imm = imm5_ext;
		case (opcode)
			op_add: begin
				dec_write = 1'b1;
				dec_aluop = alu_add;
				dec_imm_sel = if_id_instr[5];
			end
			op_and: begin
				dec_write = 1'b1;
				dec_aluop = alu_and;
				dec_imm_sel = if_id_instr[5];
			end
			op_not: begin
				dec_write = 1'b1;
				dec_aluop = alu_not;
			end
			op_shf: begin
				dec_write = 1'b1;
				dec_imm_sel = 1'b1;
				dec_imm = {12'h000, shamt};
				// bit 4 right, bit 5 arithmetic
				if (!if_id_instr[4]) begin
					dec_aluop = alu_sll;
				end else if (if_id_instr[5]) begin
					dec_aluop = alu_sra;
				end else begin
					dec_aluop = alu_srl;
				end
			end
			default: begin
				// everything else is a bubble
				dec_write = 1'b0;
			end
		endcase
	end

	// ID/EX
	always_ff @(posedge clk) begin
		if (rst) begin
			id_ex_valid <= 1'b0;
			id_ex_write <= 1'b0;
		end else begin
			id_ex_valid <= if_id_valid;
			id_ex_write <= if_id_valid && dec_write;
		end
		id_ex_aluop <= dec_aluop;
		id_ex_dest <= dest;
		id_ex_sr1 <= src_a;
		id_ex_sr2 <= src_b;
		id_ex_a <= reg_a;
		id_ex_b <= reg_b;
		id_ex_imm_sel <= dec_imm_sel;
		id_ex_imm <= dec_imm;
	end

endmodule : lc3b_decode

// ==== source/lc3b_execute.sv ====
`timescale 1ns/100ps

module lc3b_execute
(
	input logic clk,
	input logic rst,

	input logic id_ex_valid,
	input logic id_ex_write,
	input lc3b_pkg::lc3b_aluop id_ex_aluop,
	input lc3b_pkg::lc3b_reg id_ex_dest,
	input lc3b_pkg::lc3b_reg id_ex_sr1,
	input lc3b_pkg::lc3b_reg id_ex_sr2,
	input lc3b_pkg::lc3b_word id_ex_a,
	input lc3b_pkg::lc3b_word id_ex_b,
	input logic id_ex_imm_sel,
	input lc3b_pkg::lc3b_word id_ex_imm,

	lc3b_result_if.source ex_mem_res,
	lc3b_result_if.sink mem_wb_res
);
	import lc3b_pkg::*;

	logic ex_hit_ok;
	logic mem_hit_ok;
	lc3b_word fwd_a;
	lc3b_word fwd_b;
	lc3b_word op_a;
	lc3b_word op_b;
	lc3b_imm4 shamt;
	lc3b_word alu_out;

	// EX/MEM is read back from its own outputs
	assign ex_hit_ok = ex_mem_res.valid && ex_mem_res.write_en;
	assign mem_hit_ok = mem_wb_res.valid && mem_wb_res.write_en;

	// younger result wins
	function automatic lc3b_word forward_sel(
		input lc3b_reg src,
		input lc3b_word fallback
	);
		lc3b_word result;
		result = fallback;
		if (ex_hit_ok && ex_mem_res.dest == src) begin
			result = ex_mem_res.data;
		end else if (mem_hit_ok && mem_wb_res.dest == src) begin
			result = mem_wb_res.data;
		end
		return result;
	endfunction

	always_comb begin
		fwd_a = forward_sel(id_ex_sr1, id_ex_a);
		fwd_b = forward_sel(id_ex_sr2, id_ex_b);
	end

	assign op_a = fwd_a;
	// immediate never gets forwarded over
	assign op_b = id_ex_imm_sel ? id_ex_imm : fwd_b;
	assign shamt = op_b[3:0];

	always_comb begin
		case (id_ex_aluop)
			alu_add: begin
				alu_out = op_a + op_b;
			end
			alu_and: begin
				alu_out = op_a & op_b;
			end
			alu_not: begin
				alu_out = ~op_a;
			end
			alu_sll: begin
				alu_out = op_a << shamt;
			end
			alu_srl: begin
				alu_out = op_a >> shamt;
			end
			alu_sra: begin
				alu_out = lc3b_word'($signed(op_a) >>> shamt);
			end
			default: begin
				alu_out = op_a;
			end
		endcase
	end

	// EX/MEM
	always_ff @(posedge clk) begin
		if (rst) begin
			ex_mem_res.valid <= 1'b0;
			ex_mem_res.write_en <= 1'b0;
		end else begin
			ex_mem_res.valid <= id_ex_valid;
			ex_mem_res.write_en <= id_ex_write;
		end
		ex_mem_res.dest <= id_ex_dest;
		ex_mem_res.data <= alu_out;
	end

endmodule : lc3b_execute

// ==== source/lc3b_writeback.sv ====
`timescale 1ns/100ps

module lc3b_writeback
(
	input logic clk,
	input logic rst,
	lc3b_result_if.sink ex_mem_res,
	lc3b_result_if.source mem_wb_res,
	output lc3b_pkg::lc3b_nzp cc
);
	import lc3b_pkg::*;

	logic load_cc;
	lc3b_nzp gen_cc;

	assign load_cc = ex_mem_res.valid && ex_mem_res.write_en;

	// gencc on the data headed for MEM/WB
	always_comb begin
		if (ex_mem_res.data[15]) begin
			gen_cc = 3'b100;
		end else if (ex_mem_res.data == '0) begin
			gen_cc = 3'b010;
		end else begin
			gen_cc = 3'b001;
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			cc <= cc_reset;
		end else if (load_cc) begin
			cc <= gen_cc;
		end
	end

	// MEM/WB
	always_ff @(posedge clk) begin
		if (rst) begin
			mem_wb_res.valid <= 1'b0;
			mem_wb_res.write_en <= 1'b0;
		end else begin
			mem_wb_res.valid <= ex_mem_res.valid;
			mem_wb_res.write_en <= ex_mem_res.write_en;
		end
		mem_wb_res.dest <= ex_mem_res.dest;
		mem_wb_res.data <= ex_mem_res.data;
	end

endmodule : lc3b_writeback

// ==== source/lc3b_int_pipeline.sv ====
`timescale 1ns/100ps

module lc3b_int_pipeline
(
	input logic clk,
	input logic rst,
	input logic instr_valid,
	input lc3b_pkg::lc3b_word instr,
	output logic wb_valid,
	output lc3b_pkg::lc3b_reg wb_dest,
	output lc3b_pkg::lc3b_word wb_data,
	output lc3b_pkg::lc3b_nzp cc
);
	import lc3b_pkg::*;

	lc3b_reg src_a;
	lc3b_reg src_b;
	lc3b_word reg_a;
	lc3b_word reg_b;

	logic id_ex_valid;
	logic id_ex_write;
	lc3b_aluop id_ex_aluop;
	lc3b_reg id_ex_dest;
	lc3b_reg id_ex_sr1;
	lc3b_reg id_ex_sr2;
	lc3b_word id_ex_a;
	lc3b_word id_ex_b;
	logic id_ex_imm_sel;
	lc3b_word id_ex_imm;

	lc3b_result_if ex_mem_res ();
	lc3b_result_if mem_wb_res ();

	lc3b_decode lc3b_decode_inst (
		.clk,
		.rst,
		.instr_valid,
		.instr,
		.src_a,
		.src_b,
		.reg_a,
		.reg_b,
		.id_ex_valid,
		.id_ex_write,
		.id_ex_aluop,
		.id_ex_dest,
		.id_ex_sr1,
		.id_ex_sr2,
		.id_ex_a,
		.id_ex_b,
		.id_ex_imm_sel,
		.id_ex_imm
	);

	lc3b_regfile lc3b_regfile_inst (
		.clk,
		.rst,
		.src_a,
		.src_b,
		.reg_a,
		.reg_b,
		.wr(mem_wb_res.sink)
	);

	lc3b_execute lc3b_execute_inst (
		.clk,
		.rst,
		.id_ex_valid,
		.id_ex_write,
		.id_ex_aluop,
		.id_ex_dest,
		.id_ex_sr1,
		.id_ex_sr2,
		.id_ex_a,
		.id_ex_b,
		.id_ex_imm_sel,
		.id_ex_imm,
		.ex_mem_res(ex_mem_res.source),
		.mem_wb_res(mem_wb_res.sink)
	);

	lc3b_writeback lc3b_writeback_inst (
		.clk,
		.rst,
		.ex_mem_res(ex_mem_res.sink),
		.mem_wb_res(mem_wb_res.source),
		.cc
	);

	// only register writes leave the pipeline as results
	assign wb_valid = mem_wb_res.valid && mem_wb_res.write_en;
	assign wb_dest = mem_wb_res.dest;
	assign wb_data = mem_wb_res.data;

endmodule : lc3b_int_pipeline

// ==== testbench/tb_lc3b_int_pipeline.sv ====
`timescale 1ns/100ps

module tb_lc3b_int_pipeline;
	import lc3b_pkg::*;

	// opcode field values for building instructions
	localparam logic [3:0] opc_add = 4'b0001;
	localparam logic [3:0] opc_and = 4'b0101;
	localparam logic [3:0] opc_not = 4'b1001;
	localparam logic [3:0] opc_shf = 4'b1101;
	localparam int reset_cycles = 10;
	localparam int pipe_depth = 4;

	logic clk;
	logic rst;
	logic instr_valid;
	lc3b_word instr;
	logic wb_valid;
	lc3b_reg wb_dest;
	lc3b_word wb_data;
	lc3b_nzp cc;

	// stimulus table
	string tbl_name [$];
	lc3b_word tbl_instr [$];
	logic tbl_valid [$];

	// expected writes in program order
	string exp_name [$];
	lc3b_reg exp_dest [$];
	lc3b_word exp_data [$];
	lc3b_nzp exp_nzp [$];
	int exp_due [$];

	lc3b_word model_regs [8];
	lc3b_nzp cur_cc;
	string cur_cc_name;
	int cycle_count = 0;
	int cycle_limit = 1000000;

	lc3b_int_pipeline lc3b_int_pipeline_inst (
		.clk,
		.rst,
		.instr_valid,
		.instr,
		.wb_valid,
		.wb_dest,
		.wb_data,
		.cc
	);

	function automatic lc3b_word reg_mode_instr(input logic [3:0] opc, input lc3b_reg dr,
			input lc3b_reg sr1, input lc3b_reg sr2);
		return {opc, dr, sr1, 3'b000, sr2};
	endfunction

	function automatic lc3b_word imm_mode_instr(input logic [3:0] opc, input lc3b_reg dr,
			input lc3b_reg sr1, input logic [4:0] imm5);
		return {opc, dr, sr1, 1'b1, imm5};
	endfunction

	function automatic lc3b_word not_instr(input lc3b_reg dr, input lc3b_reg sr);
		return {opc_not, dr, sr, 6'b111111};
	endfunction

	function automatic lc3b_word shift_instr(input lc3b_reg dr, input lc3b_reg sr,
			input logic right, input logic arith, input lc3b_imm4 amount);
		return {opc_shf, dr, sr, arith, right, amount};
	endfunction

	function automatic lc3b_nzp nzp_of(input lc3b_word value);
		if (value[15]) begin
			return 3'b100;
		end else if (value == 16'h0000) begin
			return 3'b010;
		end
		return 3'b001;
	endfunction

	// returns 0 when the word writes no register
	function automatic logic isa_result(input lc3b_word w, output lc3b_word res);
		lc3b_word a;
		lc3b_word b;
		logic writes;
		a = model_regs[w[8:6]];
		b = w[5] ? {{11{w[4]}}, w[4:0]} : model_regs[w[2:0]];
		writes = 1'b1;
		res = 16'h0000;
		case (w[15:12])
			opc_add: res = a + b;
			opc_and: res = a & b;
			opc_not: res = ~a;
			opc_shf: begin
				if (!w[4]) begin
					res = a << w[3:0];
				end else begin
					res = a >> w[3:0];
					// arithmetic shift fills with the sign
					if (w[5] && a[15]) begin
						res = res | ~(16'hffff >> w[3:0]);
					end
				end
			end
			default: writes = 1'b0;
		endcase
		return writes;
	endfunction

	task automatic stop_with_failure(input string why);
		$display("%s", why);
		$display("TESTBENCH FAILED");
		$fatal(1, "simulation stopped on error");
	endtask

	task automatic add_entry(input string name, input lc3b_word word, input logic valid);
		tbl_name.push_back(name);
		tbl_instr.push_back(word);
		tbl_valid.push_back(valid);
	endtask

	task automatic build_table();
		int unsigned r;
		lc3b_word w;
		lc3b_imm4 amount;
		for (int i = 0; i < 3; i++) begin
			r = $urandom;
			add_entry("idle_after_reset", r[15:0], 1'b0);
		end
		add_entry("add_imm_zero_src", imm_mode_instr(opc_add, 3'd1, 3'd0, 5'h07), 1'b1);
		add_entry("add_imm_neg", imm_mode_instr(opc_add, 3'd2, 3'd3, 5'h10), 1'b1);
		add_entry("bubble_br", 16'h0fff, 1'b1);
		add_entry("add_reg", reg_mode_instr(opc_add, 3'd3, 3'd1, 3'd2), 1'b1);
		add_entry("and_imm", imm_mode_instr(opc_and, 3'd4, 3'd3, 5'h0f), 1'b1);
		add_entry("and_imm_neg", imm_mode_instr(opc_and, 3'd5, 3'd3, 5'h1c), 1'b1);
		add_entry("and_reg", reg_mode_instr(opc_and, 3'd6, 3'd3, 3'd2), 1'b1);
		add_entry("and_zero", imm_mode_instr(opc_and, 3'd7, 3'd1, 5'h00), 1'b1);
		add_entry("not_of_zero", not_instr(3'd0, 3'd7), 1'b1);
		add_entry("bubble_trap", 16'hf025, 1'b1);
		add_entry("bubble_ldr", 16'h6242, 1'b1);
		add_entry("idle_add_word", 16'h1234, 1'b0);
		add_entry("not_of_neg", not_instr(3'd0, 3'd6), 1'b1);
		// dependent chain at distance 1, 2 and 3
		add_entry("chain_d1_a", imm_mode_instr(opc_add, 3'd1, 3'd1, 5'h09), 1'b1);
		add_entry("chain_d1_b", reg_mode_instr(opc_add, 3'd1, 3'd1, 3'd1), 1'b1);
		add_entry("idle_chain", 16'h0000, 1'b0);
		add_entry("chain_d2", imm_mode_instr(opc_add, 3'd2, 3'd1, 5'h1f), 1'b1);
		add_entry("idle_chain", 16'h0000, 1'b0);
		add_entry("idle_chain", 16'h0000, 1'b0);
		add_entry("chain_d3", reg_mode_instr(opc_and, 3'd3, 3'd0, 3'd2), 1'b1);
		add_entry("chain_mixed", reg_mode_instr(opc_add, 3'd4, 3'd3, 3'd2), 1'b1);
		add_entry("chain_not", not_instr(3'd4, 3'd4), 1'b1);
		add_entry("shift_src_neg", imm_mode_instr(opc_add, 3'd5, 3'd7, 5'h15), 1'b1);
		add_entry("shift_src_pos", not_instr(3'd6, 3'd5), 1'b1);
		for (int i = 0; i < 16; i++) begin
			amount = i[3:0];
			add_entry($sformatf("lshf_%0d", i), shift_instr(3'd1, 3'd5, 1'b0, 1'b0, amount), 1'b1);
			add_entry($sformatf("rshfl_%0d", i), shift_instr(3'd2, 3'd5, 1'b1, 1'b0, amount), 1'b1);
			add_entry($sformatf("rshfa_%0d", i), shift_instr(3'd3, 3'd5, 1'b1, 1'b1, amount), 1'b1);
			add_entry($sformatf("rshfa_pos_%0d", i), shift_instr(3'd4, 3'd6, 1'b1, 1'b1, amount),
				1'b1);
		end
		// random block with random gaps
		for (int i = 0; i < 64; i++) begin
			r = $urandom;
			if (r[31:30] == 2'b00) begin
				add_entry("random_gap", r[15:0], 1'b0);
			end
			r = $urandom;
			case (r[1:0])
				2'd0, 2'd1: begin
					if (r[2]) begin
						w = imm_mode_instr(r[0] ? opc_and : opc_add, r[5:3], r[8:6], r[13:9]);
					end else begin
						w = reg_mode_instr(r[0] ? opc_and : opc_add, r[5:3], r[8:6], r[11:9]);
					end
				end
				2'd2: w = not_instr(r[5:3], r[8:6]);
				default: w = shift_instr(r[5:3], r[8:6], r[9], r[10], r[14:11]);
			endcase
			add_entry($sformatf("random_%0d", i), w, 1'b1);
		end
	endtask

	task automatic apply_entry(input int idx);
		lc3b_word w;
		lc3b_word res;
		logic writes;
		w = tbl_instr[idx];
		instr_valid <= tbl_valid[idx];
		instr <= w;
		writes = isa_result(w, res);
		if (tbl_valid[idx] && writes) begin
			model_regs[w[11:9]] = res;
			exp_name.push_back(tbl_name[idx]);
			exp_dest.push_back(w[11:9]);
			exp_data.push_back(res);
			exp_nzp.push_back(nzp_of(res));
			// counter still holds the count before this edge
			exp_due.push_back(cycle_count + pipe_depth + 1);
		end
	endtask

	task automatic check_outputs();
		string name;
		if (wb_valid) begin
			assert (exp_name.size() > 0) else begin
				stop_with_failure("wb_valid went high while no register write was expected");
			end
			name = exp_name.pop_front();
			assert (cycle_count == exp_due[0]) else begin
				stop_with_failure($sformatf("Fail %s: write cycle expected %0d, actual %0d",
					name, exp_due[0], cycle_count));
			end
			assert (wb_dest == exp_dest[0]) else begin
				stop_with_failure($sformatf("Fail %s: dest expected R%0d, actual R%0d",
					name, exp_dest[0], wb_dest));
			end
			assert (wb_data == exp_data[0]) else begin
				stop_with_failure($sformatf("Fail %s: data expected 16'h%04h, actual 16'h%04h",
					name, exp_data[0], wb_data));
			end
			cur_cc = exp_nzp[0];
			cur_cc_name = name;
			void'(exp_dest.pop_front());
			void'(exp_data.pop_front());
			void'(exp_nzp.pop_front());
			void'(exp_due.pop_front());
		end
		assert (cc == cur_cc) else begin
			stop_with_failure($sformatf("Fail cc_after_%s: cc expected 3'b%03b, actual 3'b%03b",
				cur_cc_name, cur_cc, cc));
		end
	endtask

	initial begin
		clk = 1'b0;
		forever begin
			#50 clk = ~clk;
		end
	end

	always @(posedge clk) begin
		cycle_count <= cycle_count + 1;
		if (cycle_count >= cycle_limit) begin
			stop_with_failure($sformatf("timeout: run did not finish within %0d cycles",
				cycle_limit));
		end
	end

	// outputs are settled at the falling edge
	always @(negedge clk) begin
		if (!rst) begin
			check_outputs();
		end
	end

	initial begin
		void'($urandom(32'hc5d7_e43a));
		rst = 1'b1;
		instr_valid = 1'b0;
		instr = 16'h0000;
		for (int i = 0; i < 8; i++) begin
			model_regs[i] = 16'h0000;
		end
		// zero flag set out of reset
		cur_cc = 3'b010;
		cur_cc_name = "reset";
		build_table();
		cycle_limit = tbl_name.size() + reset_cycles + 20;
		repeat (reset_cycles) @(posedge clk);
		rst <= 1'b0;
		for (int i = 0; i < tbl_name.size(); i++) begin
			@(posedge clk);
			apply_entry(i);
		end
		@(posedge clk);
		instr_valid <= 1'b0;
		repeat (pipe_depth) @(posedge clk);
		if (exp_name.size() == 0) begin
			$display("TESTBENCH PASSED");
			$finish;
		end else begin
			stop_with_failure($sformatf("%0d expected writes never left the pipeline",
				exp_name.size()));
		end
	end

endmodule : tb_lc3b_int_pipeline

// ==== flist.f ====
source/lc3b_pkg.sv
source/lc3b_result_if.sv
source/lc3b_regfile.sv
source/lc3b_decode.sv
source/lc3b_execute.sv
source/lc3b_writeback.sv
source/lc3b_int_pipeline.sv
testbench/tb_lc3b_int_pipeline.sv

// ==== Makefile ====
# Verilator build and run for the LC-3b integer pipeline

VERILATOR ?= verilator
TOP ?= tb_lc3b_int_pipeline
FLIST ?= flist.f
BUILD_DIR ?= obj_dir
TIMESCALE ?= 1ns/100ps
VFLAGS ?= --binary --timing --assert
EXTRA_FLAGS ?=

SIM_BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: sim clean

# the simulator exits non-zero on $fatal, so make fails with it
sim:
	$(VERILATOR) $(VFLAGS) $(EXTRA_FLAGS) --timescale $(TIMESCALE) \
		--top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FLIST)
	./$(SIM_BIN)

clean:
	rm -rf $(BUILD_DIR)
